// File: hw/hbus_params.svh
`ifndef HBUS_PARAMS_SVH
`define HBUS_PARAMS_SVH

// Wishbone side widths
`define HBUS_WB_DW 32
`define HBUS_WB_AW 32

// HyperBus side widths, address counts halfwords
`define HBUS_AW 32
`define HBUS_DW 16

// Mapped window, base in bytes and size in 32-bit words
`define HBUS_WIN_BASE 32'h0000_0000
`define HBUS_WIN_WORDS 256

`endif

// File: hw/hbus_pkg.sv
`include "hbus_params.svh"

package hbus_pkg;

  // One Wishbone data word
  typedef logic [`HBUS_WB_DW-1:0] word_t;

  // Command handed from decode to the beat sequencer
  typedef struct packed {
    logic               we;
    logic [`HBUS_AW-1:0] word_adr;
    word_t              wdata;
  } hbus_cmd_t;

  // Which Wishbone response line ends the cycle
  typedef enum logic [1:0] {
    RESP_ACK = 2'd0,
    RESP_ERR = 2'd1,
    RESP_RTY = 2'd2
  } hbus_status_e;

  // Registered response, status plus read word
  typedef struct packed {
    hbus_status_e status;
    word_t        rdata;
  } hbus_result_t;

endpackage

// File: hw/hbus_wb_decode.sv
`include "hbus_params.svh"

module hbus_wb_decode (
  input  logic                        wb_clk,
  input  logic                        wb_rst,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [`HBUS_WB_DW/8-1:0]    wb_sel_i,
  input  logic [`HBUS_WB_AW-1:0]      wb_adr_i,
  input  logic [`HBUS_WB_DW-1:0]      wb_dat_i,
  input  logic                        hbus_busy_i,
  input  logic                        resp_pulse_i,
  output hbus_pkg::hbus_cmd_t         cmd_o,
  output logic                        cmd_valid_o,
  output logic                        fault_valid_o,
  output hbus_pkg::hbus_status_e      fault_o
);

  logic                   armed_q;
  logic                   accept;
  logic [`HBUS_WB_AW-1:0] offset;
  logic                   in_window;
  logic                   bad_sel;
  logic                   is_fault;

  assign accept = armed_q & wb_cyc_i & wb_stb_i;

  // Addresses below the base wrap to a large offset and fall outside too
  assign offset    = wb_adr_i - `HBUS_WIN_BASE;
  assign in_window = offset[`HBUS_WB_AW-1:2] < `HBUS_WIN_WORDS;

  // No byte mask on HyperBus, so partial writes are refused
  assign bad_sel  = wb_we_i & ~(&wb_sel_i);
  assign is_fault = ~in_window | bad_sel | hbus_busy_i;

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      armed_q       <= 1'b1;
      cmd_valid_o   <= 1'b0;
      fault_valid_o <= 1'b0;
    end else begin
      cmd_valid_o   <= accept & ~is_fault;
      fault_valid_o <= accept & is_fault;
      // Stay deaf to stb until the response has gone out
      if (accept) begin
        armed_q <= 1'b0;
      end else if (resp_pulse_i) begin
        armed_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge wb_clk) begin
    if (accept) begin
      // Window and sel faults win over busy
      if (~in_window | bad_sel) begin
        fault_o <= hbus_pkg::RESP_ERR;
      end else begin
        fault_o <= hbus_pkg::RESP_RTY;
      end
      cmd_o.we       <= wb_we_i;
      cmd_o.word_adr <= `HBUS_AW'(offset[`HBUS_WB_AW-1:2]);
      cmd_o.wdata    <= wb_dat_i;
    end
  end

endmodule

// File: hw/hbus_beat_sequencer.sv
`include "hbus_params.svh"

module hbus_beat_sequencer (
  input  logic                     wb_clk,
  input  logic                     wb_rst,
  input  hbus_pkg::hbus_cmd_t      cmd_i,
  input  logic                     cmd_valid_i,
  input  logic                     hbus_ready_i,
  input  logic                     hbus_valid_i,
  input  logic [`HBUS_DW-1:0]      hbus_dat_i,
  output logic [`HBUS_AW-1:0]      hbus_adr_o,
  output logic [`HBUS_DW-1:0]      hbus_dat_o,
  output logic                     hbus_rrq_o,
  output logic                     hbus_wrq_o,
  output logic                     done_o,
  output hbus_pkg::word_t          rdata_o
);

  // One-hot state encoding
  localparam logic [3:0] ST_IDLE   = 4'b0001;
  localparam logic [3:0] ST_REQ    = 4'b0010;
  localparam logic [3:0] ST_AWAIT  = 4'b0100;
  localparam logic [3:0] ST_FINISH = 4'b1000;

  logic [3:0]          state_q;
  logic                beat_q;
  hbus_pkg::hbus_cmd_t cmd_q;
  hbus_pkg::word_t     rdata_q;
  logic                req_active;
  logic                read_done;

  assign req_active = (state_q == ST_REQ);
  assign read_done  = (state_q == ST_AWAIT) & hbus_valid_i;

  assign hbus_rrq_o = req_active & ~cmd_q.we;
  assign hbus_wrq_o = req_active & cmd_q.we;

  // Beat 0 at twice the word index, beat 1 at the halfword after
  assign hbus_adr_o = {cmd_q.word_adr[`HBUS_AW-2:0], beat_q};
  assign hbus_dat_o = beat_q ? cmd_q.wdata[2*`HBUS_DW-1:`HBUS_DW]
                             : cmd_q.wdata[`HBUS_DW-1:0];

  assign done_o  = (state_q == ST_FINISH);
  assign rdata_o = rdata_q;

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      state_q <= ST_IDLE;
      beat_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          beat_q <= 1'b0;
          if (cmd_valid_i) begin
            state_q <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (hbus_ready_i) begin
            if (!cmd_q.we) begin
              state_q <= ST_AWAIT;
            end else if (beat_q) begin
              state_q <= ST_FINISH;
            end else begin
              beat_q <= 1'b1;
            end
          end
        end
        ST_AWAIT: begin
          // Read beat ends when the device returns the halfword
          if (hbus_valid_i) begin
            if (beat_q) begin
              state_q <= ST_FINISH;
            end else begin
              beat_q  <= 1'b1;
              state_q <= ST_REQ;
            end
          end
        end
        ST_FINISH: begin
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Command is held for the whole exchange
  always_ff @(posedge wb_clk) begin
    if (cmd_valid_i && state_q == ST_IDLE) begin
      cmd_q <= cmd_i;
    end
  end

  // Gather read halves with the low half first
  always_ff @(posedge wb_clk) begin
    if (read_done) begin
      if (beat_q) begin
        rdata_q[2*`HBUS_DW-1:`HBUS_DW] <= hbus_dat_i;
      end else begin
        rdata_q[`HBUS_DW-1:0] <= hbus_dat_i;
      end
    end
  end

endmodule

// File: hw/hbus_wb_response.sv
`include "hbus_params.svh"

module hbus_wb_response (
  input  logic                     wb_clk,
  input  logic                     wb_rst,
  input  logic                     done_i,
  input  hbus_pkg::word_t          rdata_i,
  input  logic                     fault_valid_i,
  input  hbus_pkg::hbus_status_e   fault_i,
  output logic [`HBUS_WB_DW-1:0]   wb_dat_o,
  output logic                     wb_ack_o,
  output logic                     wb_err_o,
  output logic                     wb_rty_o,
  output logic                     resp_pulse_o
);

  hbus_pkg::hbus_result_t result_q;
  logic                   resp_q;

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      resp_q <= 1'b0;
    end else begin
      resp_q <= done_i | fault_valid_i;
    end
  end

  // Read word only moves on completion, a fault keeps the last one
  always_ff @(posedge wb_clk) begin
    if (done_i) begin
      result_q.status <= hbus_pkg::RESP_ACK;
      result_q.rdata  <= rdata_i;
    end else if (fault_valid_i) begin
      result_q.status <= fault_i;
    end
  end

  assign wb_ack_o = resp_q & (result_q.status == hbus_pkg::RESP_ACK);
  assign wb_err_o = resp_q & (result_q.status == hbus_pkg::RESP_ERR);
  assign wb_rty_o = resp_q & (result_q.status == hbus_pkg::RESP_RTY);

  assign wb_dat_o     = result_q.rdata;
  assign resp_pulse_o = resp_q;

endmodule

// File: hw/hyperbus_wishbone.sv
`include "hbus_params.svh"

module hyperbus_wishbone (
  input  logic                        wb_clk,
  input  logic                        wb_rst,

  // Wishbone classic slave
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [`HBUS_WB_DW/8-1:0]    wb_sel_i,
  input  logic [`HBUS_WB_AW-1:0]      wb_adr_i,
  input  logic [`HBUS_WB_DW-1:0]      wb_dat_i,
  output logic [`HBUS_WB_DW-1:0]      wb_dat_o,
  output logic                        wb_ack_o,
  output logic                        wb_err_o,
  output logic                        wb_rty_o,

  // HyperBus controller port
  output logic [`HBUS_AW-1:0]         hbus_adr_o,
  output logic [`HBUS_DW-1:0]         hbus_dat_o,
  output logic                        hbus_rrq,
  output logic                        hbus_wrq,
  input  logic [`HBUS_DW-1:0]         hbus_dat_i,
  input  logic                        hbus_ready,
  input  logic                        hbus_valid,
  input  logic                        hbus_busy
);

  hbus_pkg::hbus_cmd_t    cmd;
  logic                   cmd_valid;
  logic                   fault_valid;
  hbus_pkg::hbus_status_e fault;
  logic                   done;
  hbus_pkg::word_t        rdata;
  logic                   resp_pulse;

  hbus_wb_decode u_decode (
    .wb_clk        (wb_clk),
    .wb_rst        (wb_rst),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_sel_i      (wb_sel_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .hbus_busy_i   (hbus_busy),
    .resp_pulse_i  (resp_pulse),
    .cmd_o         (cmd),
    .cmd_valid_o   (cmd_valid),
    .fault_valid_o (fault_valid),
    .fault_o       (fault)
  );

  hbus_beat_sequencer u_sequencer (
    .wb_clk       (wb_clk),
    .wb_rst       (wb_rst),
    .cmd_i        (cmd),
    .cmd_valid_i  (cmd_valid),
    .hbus_ready_i (hbus_ready),
    .hbus_valid_i (hbus_valid),
    .hbus_dat_i   (hbus_dat_i),
    .hbus_adr_o   (hbus_adr_o),
    .hbus_dat_o   (hbus_dat_o),
    .hbus_rrq_o   (hbus_rrq),
    .hbus_wrq_o   (hbus_wrq),
    .done_o       (done),
    .rdata_o      (rdata)
  );

  hbus_wb_response u_response (
    .wb_clk        (wb_clk),
    .wb_rst        (wb_rst),
    .done_i        (done),
    .rdata_i       (rdata),
    .fault_valid_i (fault_valid),
    .fault_i       (fault),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .wb_err_o      (wb_err_o),
    .wb_rty_o      (wb_rty_o),
    .resp_pulse_o  (resp_pulse)
  );

endmodule

// File: dv/hbus_device_model.sv
`include "hbus_params.svh"

module hbus_device_model (
  input  logic                wb_clk,
  input  logic                wb_rst,
  input  logic                busy_i,
  input  logic                rrq_i,
  input  logic                wrq_i,
  input  logic [`HBUS_AW-1:0] adr_i,
  input  logic [`HBUS_DW-1:0] dat_i,
  input  logic [`HBUS_AW-1:0] exp_word_i,
  input  hbus_pkg::word_t     exp_wdata_i,
  output logic                busy_o,
  output logic                ready_o,
  output logic                valid_o,
  output logic [`HBUS_DW-1:0] dat_o,
  output int                  wr_beats_o,
  output int                  rd_beats_o,
  output logic                error_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`HBUS_DW-1:0] mem [512];
  logic [15:0]         lfsr = 16'd65;
  logic [1:0]          delay;
  logic [1:0]          wait_cnt;
  logic                req_seen;
  logic                rd_pending;
  logic [8:0]          rd_adr;
  logic                wr_beat;
  logic                rd_beat;

  assign busy_o = busy_i;

  // Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Two fresh bits give a delay of 0 to 3 cycles
  task automatic draw_delay(output logic [1:0] d);
    lfsr = lfsr_next(lfsr);
    d[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    d[1] = lfsr[0];
  endtask

  function automatic logic beat_ok(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      return 1'b0;
    end
    return 1'b1;
  endfunction

  initial begin
    for (int i = 0; i < 512; i++) begin
      mem[i] = 16'hC300 ^ 16'(i);
    end
  end

  always @(posedge wb_clk) begin
    if (wb_rst) begin
      ready_o    <= 1'b0;
      valid_o    <= 1'b0;
      dat_o      <= '0;
      req_seen   <= 1'b0;
      rd_pending <= 1'b0;
      wait_cnt   <= 2'd0;
      wr_beat    <= 1'b0;
      rd_beat    <= 1'b0;
      wr_beats_o <= 0;
      rd_beats_o <= 0;
      error_o    <= 1'b0;
    end else begin
      valid_o <= 1'b0;
      if (ready_o) begin
        // Request handshake on this edge
        ready_o <= 1'b0;
        if (wrq_i) begin
          if (!beat_ok("hbus_adr_o", adr_i, 2 * exp_word_i + 32'(wr_beat)) ||
              !beat_ok("hbus_dat_o", 32'(dat_i),
                       32'(wr_beat ? exp_wdata_i[31:16] : exp_wdata_i[15:0]))) begin
            error_o <= 1'b1;
          end
          mem[adr_i[8:0]] <= dat_i;
          wr_beat         <= ~wr_beat;
          wr_beats_o      <= wr_beats_o + 1;
        end else if (rrq_i) begin
          if (!beat_ok("hbus_adr_o", adr_i, 2 * exp_word_i + 32'(rd_beat))) begin
            error_o <= 1'b1;
          end
          draw_delay(delay);
          wait_cnt   <= delay;
          rd_adr     <= adr_i[8:0];
          rd_pending <= 1'b1;
          rd_beat    <= ~rd_beat;
          rd_beats_o <= rd_beats_o + 1;
        end
      end else if (rd_pending) begin
        if (wait_cnt == 2'd0) begin
          valid_o    <= 1'b1;
          dat_o      <= mem[rd_adr];
          rd_pending <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end else if (rrq_i || wrq_i) begin
        if (!req_seen) begin
          draw_delay(delay);
          wait_cnt <= delay;
          req_seen <= 1'b1;
        end else if (wait_cnt == 2'd0) begin
          ready_o  <= 1'b1;
          req_seen <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
    end
  end

endmodule

// File: dv/tb_hyperbus_wishbone.sv
`include "hbus_params.svh"

module tb_hyperbus_wishbone;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ROWS = 17;
  localparam int TIMEOUT  = 200;
  localparam hbus_pkg::hbus_status_e ACK = hbus_pkg::RESP_ACK;
  localparam hbus_pkg::hbus_status_e ERR = hbus_pkg::RESP_ERR;
  localparam hbus_pkg::hbus_status_e RTY = hbus_pkg::RESP_RTY;

  typedef struct packed {
    logic                     we;
    logic [`HBUS_WB_AW-1:0]   adr;
    hbus_pkg::word_t          wdata;
    logic [`HBUS_WB_DW/8-1:0] sel;
    logic                     busy;
    hbus_pkg::hbus_status_e   exp_status;
    hbus_pkg::word_t          exp_rdata;
  } row_t;

  logic                     wb_clk;
  logic                     wb_rst;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [`HBUS_WB_DW/8-1:0] wb_sel;
  logic [`HBUS_WB_AW-1:0]   wb_adr;
  logic [`HBUS_WB_DW-1:0]   wb_dat_w;
  logic [`HBUS_WB_DW-1:0]   wb_dat_r;
  logic                     wb_ack;
  logic                     wb_err;
  logic                     wb_rty;
  logic [`HBUS_AW-1:0]      hbus_adr;
  logic [`HBUS_DW-1:0]      hbus_dat_w;
  logic [`HBUS_DW-1:0]      hbus_dat_r;
  logic                     hbus_rrq;
  logic                     hbus_wrq;
  logic                     hbus_ready;
  logic                     hbus_valid;
  logic                     hbus_busy;
  logic                     tb_busy;
  logic [`HBUS_AW-1:0]      exp_word;
  hbus_pkg::word_t          exp_wdata;
  int                       wr_beats;
  int                       rd_beats;
  logic                     model_error;
  row_t                     rows [NUM_ROWS];

  hyperbus_wishbone u_hyperbus_wishbone (
    .wb_clk     (wb_clk),
    .wb_rst     (wb_rst),
    .wb_cyc_i   (wb_cyc),
    .wb_stb_i   (wb_stb),
    .wb_we_i    (wb_we),
    .wb_sel_i   (wb_sel),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_w),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack),
    .wb_err_o   (wb_err),
    .wb_rty_o   (wb_rty),
    .hbus_adr_o (hbus_adr),
    .hbus_dat_o (hbus_dat_w),
    .hbus_rrq   (hbus_rrq),
    .hbus_wrq   (hbus_wrq),
    .hbus_dat_i (hbus_dat_r),
    .hbus_ready (hbus_ready),
    .hbus_valid (hbus_valid),
    .hbus_busy  (hbus_busy)
  );

  hbus_device_model u_device (
    .wb_clk      (wb_clk),
    .wb_rst      (wb_rst),
    .busy_i      (tb_busy),
    .rrq_i       (hbus_rrq),
    .wrq_i       (hbus_wrq),
    .adr_i       (hbus_adr),
    .dat_i       (hbus_dat_w),
    .exp_word_i  (exp_word),
    .exp_wdata_i (exp_wdata),
    .busy_o      (hbus_busy),
    .ready_o     (hbus_ready),
    .valid_o     (hbus_valid),
    .dat_o       (hbus_dat_r),
    .wr_beats_o  (wr_beats),
    .rd_beats_o  (rd_beats),
    .error_o     (model_error)
  );

  initial begin
    wb_clk = 1'b0;
    forever #2 wb_clk = ~wb_clk;
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_status(input string name, input hbus_pkg::hbus_status_e got,
                              input hbus_pkg::hbus_status_e exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input hbus_pkg::word_t got,
                            input hbus_pkg::word_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_response_idle();
    check_bit("wb_ack_o", wb_ack, 1'b0);
    check_bit("wb_err_o", wb_err, 1'b0);
    check_bit("wb_rty_o", wb_rty, 1'b0);
  endtask

  function automatic row_t make_row(input logic we, input logic [31:0] adr,
                                    input logic [31:0] wdata, input logic [3:0] sel,
                                    input logic busy, input hbus_pkg::hbus_status_e status,
                                    input logic [31:0] rdata);
    return '{we, adr, wdata, sel, busy, status, rdata};
  endfunction

  // Word 255 is the last one inside the window and byte 0x400 the first outside
  task automatic load_rows();
    rows[0]  = make_row(1'b1, 32'h0000_0010, 32'hDEAD_BEEF, 4'hF, 1'b0, ACK, 32'h0);
    rows[1]  = make_row(1'b0, 32'h0000_0010, 32'h0, 4'hF, 1'b0, ACK, 32'hDEAD_BEEF);
    rows[2]  = make_row(1'b1, 32'h0000_03FC, 32'h1234_5678, 4'hF, 1'b0, ACK, 32'h0);
    rows[3]  = make_row(1'b0, 32'h0000_03FC, 32'h0, 4'hF, 1'b0, ACK, 32'h1234_5678);
    rows[4]  = make_row(1'b1, 32'h0000_0400, 32'h5555_AAAA, 4'hF, 1'b0, ERR, 32'h0);
    rows[5]  = make_row(1'b0, 32'h0000_0400, 32'h0, 4'hF, 1'b0, ERR, 32'h0);
    rows[6]  = make_row(1'b0, 32'h8000_0000, 32'h0, 4'hF, 1'b0, ERR, 32'h0);
    rows[7]  = make_row(1'b1, 32'h0000_0010, 32'h0BAD_F00D, 4'h3, 1'b0, ERR, 32'h0);
    rows[8]  = make_row(1'b0, 32'h0000_0010, 32'h0, 4'hF, 1'b0, ACK, 32'hDEAD_BEEF);
    rows[9]  = make_row(1'b0, 32'h0000_0010, 32'h0, 4'h1, 1'b0, ACK, 32'hDEAD_BEEF);
    rows[10] = make_row(1'b1, 32'h0000_0020, 32'hCAFE_0001, 4'hF, 1'b1, RTY, 32'h0);
    rows[11] = make_row(1'b1, 32'h0000_0020, 32'hCAFE_0001, 4'hF, 1'b0, ACK, 32'h0);
    rows[12] = make_row(1'b0, 32'h0000_0020, 32'h0, 4'hF, 1'b1, RTY, 32'h0);
    rows[13] = make_row(1'b0, 32'h0000_0020, 32'h0, 4'hF, 1'b0, ACK, 32'hCAFE_0001);
    rows[14] = make_row(1'b1, 32'h0000_0400, 32'h0, 4'hF, 1'b1, ERR, 32'h0);
    rows[15] = make_row(1'b1, 32'h0000_0024, 32'hA5A5_5A5A, 4'hF, 1'b0, ACK, 32'h0);
    rows[16] = make_row(1'b0, 32'h0000_0024, 32'h0, 4'hF, 1'b0, ACK, 32'hA5A5_5A5A);
  endtask

  // Called 1 ns after a rising edge
  task automatic run_row(input row_t r);
    int                     n;
    int                     wr_start;
    int                     rd_start;
    logic                   got;
    hbus_pkg::hbus_status_e seen;
    n        = 0;
    got      = 1'b0;
    wr_start = wr_beats;
    rd_start = rd_beats;
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    wb_we     = r.we;
    wb_sel    = r.sel;
    wb_adr    = r.adr;
    wb_dat_w  = r.wdata;
    tb_busy   = r.busy;
    exp_word  = `HBUS_AW'((r.adr - `HBUS_WIN_BASE) >> 2);
    exp_wdata = r.wdata;
    while (!got && n < TIMEOUT) begin
      @(posedge wb_clk);
      #1;
      n++;
      if (wb_ack || wb_err || wb_rty) begin
        got = 1'b1;
      end else if (r.exp_status != ACK) begin
        check_bit("hbus_rrq", hbus_rrq, 1'b0);
        check_bit("hbus_wrq", hbus_wrq, 1'b0);
      end
    end
    if (!got) begin
      $display("Timeout: no Wishbone response within %0d cycles at %0t", TIMEOUT, $time);
      abort_run();
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    check_count("response lines", int'(wb_ack) + int'(wb_err) + int'(wb_rty), 1);
    if (wb_ack) begin
      seen = ACK;
    end else if (wb_err) begin
      seen = ERR;
    end else begin
      seen = RTY;
    end
    check_status("wb response", seen, r.exp_status);
    if (r.exp_status != ACK) begin
      check_count("fault latency", n, 2);
    end else if (n < 6) begin
      $display("Ack arrived only %0d cycles after stb at %0t", n, $time);
      abort_run();
    end
    if (!r.we && seen == ACK) begin
      check_data("wb_dat_o", wb_dat_r, r.exp_rdata);
    end
    check_count("wrq beats", wr_beats - wr_start, (r.we && r.exp_status == ACK) ? 2 : 0);
    check_count("rrq beats", rd_beats - rd_start, (!r.we && r.exp_status == ACK) ? 2 : 0);
    // The response lasts a single cycle
    @(posedge wb_clk);
    #1;
    check_response_idle();
  endtask

  always @(posedge wb_clk) begin
    if (model_error) begin
      $display("HyperBus device model saw a wrong beat at %0t", $time);
      abort_run();
    end
  end

  initial begin
    wb_rst    = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_sel    = '0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    tb_busy   = 1'b0;
    exp_word  = '0;
    exp_wdata = '0;
    load_rows();
    repeat (3) @(posedge wb_clk);
    #1;
    wb_rst = 1'b0;
    // Nothing moves before the first request
    repeat (5) begin
      @(posedge wb_clk);
      #1;
      check_response_idle();
      check_bit("hbus_rrq", hbus_rrq, 1'b0);
      check_bit("hbus_wrq", hbus_wrq, 1'b0);
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+hw
hw/hbus_pkg.sv
hw/hbus_wb_decode.sv
hw/hbus_beat_sequencer.sv
hw/hbus_wb_response.sv
hw/hyperbus_wishbone.sv
dv/hbus_device_model.sv
dv/tb_hyperbus_wishbone.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --timescale 1ns/100ps -j 0
TOP       := tb_hyperbus_wishbone
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
